/* Bender.yml */
package:
  name: fpu_unit

sources:
  - rtl/fpu_pkg.sv
  - rtl/fpu_tag_store.sv
  - rtl/fpu_lane.sv
  - rtl/fpu_core.sv
  - rtl/fpu_fflags_acc.sv
  - rtl/fpu_unit.sv
  - target: test
    files:
      - testbench/fpu_unit_props.sv
      - testbench/fpu_unit_tb.sv

/* all.f */
rtl/fpu_pkg.sv
rtl/fpu_tag_store.sv
rtl/fpu_lane.sv
rtl/fpu_core.sv
rtl/fpu_fflags_acc.sv
rtl/fpu_unit.sv
testbench/fpu_unit_props.sv
testbench/fpu_unit_tb.sv

/* rtl/fpu_core.sv */
`timescale 1ns/1ps

module fpu_core #(
    parameter int NUM_LANES = 2,
    parameter int TAG_WIDTH = 2
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  fpu_pkg::fpu_op_t                op,
    input  fpu_pkg::frm_t                   frm,
    input  logic [NUM_LANES-1:0]            mask,
    input  fpu_pkg::word_t [NUM_LANES-1:0]  a,
    input  fpu_pkg::word_t [NUM_LANES-1:0]  b,
    input  logic [TAG_WIDTH-1:0]            in_tag,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic [TAG_WIDTH-1:0]            out_tag,
    output fpu_pkg::word_t [NUM_LANES-1:0]  result,
    output fpu_pkg::fflags_t                fflags,
    output logic                            has_fflags
);

    logic                           s1_valid;
    logic                           s1_ready;
    fpu_pkg::fpu_op_t               s1_op;
    fpu_pkg::frm_t                  s1_frm;
    logic [NUM_LANES-1:0]           s1_mask;
    fpu_pkg::word_t [NUM_LANES-1:0] s1_a;
    fpu_pkg::word_t [NUM_LANES-1:0] s1_b;
    logic [TAG_WIDTH-1:0]           s1_tag;

    logic                           s2_valid;
    logic                           s2_ready;

    fpu_pkg::word_t [NUM_LANES-1:0]   lane_result;
    fpu_pkg::fflags_t [NUM_LANES-1:0] lane_fflags;
    fpu_pkg::fflags_t                 merged_fflags;

    assign s2_ready = !s2_valid || out_ready;
    assign s1_ready = !s1_valid || s2_ready;
    assign in_ready = s1_ready;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lanes
        fpu_lane i_fpu_lane (
            .op     (s1_op),
            .frm    (s1_frm),
            .a      (s1_a[i]),
            .b      (s1_b[i]),
            .result (lane_result[i]),
            .fflags (lane_fflags[i])
        );
    end

    // Inactive threads contribute no flags
    always_comb begin
        merged_fflags = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (s1_mask[i]) begin
                merged_fflags = merged_fflags | lane_fflags[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid <= in_valid;
            end
            if (s2_ready) begin
                s2_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && s1_ready) begin
            s1_op   <= op;
            s1_frm  <= frm;
            s1_mask <= mask;
            s1_a    <= a;
            s1_b    <= b;
            s1_tag  <= in_tag;
        end
        if (s1_valid && s2_ready) begin
            result     <= lane_result;
            fflags     <= merged_fflags;
            has_fflags <= (s1_op != fpu_pkg::FPU_SGNJ);
            out_tag    <= s1_tag;
        end
    end

    assign out_valid = s2_valid;

endmodule

/* rtl/fpu_fflags_acc.sv */
`timescale 1ns/1ps

module fpu_fflags_acc (
    input  logic             clk,
    input  logic             reset,
    input  logic             fire,
    input  logic             eop,
    input  logic             has_fflags,
    input  fpu_pkg::wid_t    wid,
    input  fpu_pkg::fflags_t fflags,
    output logic             csr_write_enable,
    output fpu_pkg::wid_t    csr_write_wid,
    output fpu_pkg::fflags_t csr_write_fflags
);

    fpu_pkg::fflags_t acc;
    fpu_pkg::fflags_t acc_next;

    // Flags of earlier packets plus the current one
    assign acc_next = acc | fflags;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc              <= '0;
            csr_write_enable <= 1'b0;
        end else begin
            if (fire) begin
                acc <= eop ? '0 : acc_next;
            end
            csr_write_enable <= fire && eop && has_fflags;
        end
    end

    always_ff @(posedge clk) begin
        csr_write_wid    <= wid;
        csr_write_fflags <= acc_next;
    end

endmodule

/* rtl/fpu_lane.sv */
`timescale 1ns/1ps

module fpu_lane (
    input  fpu_pkg::fpu_op_t op,
    input  fpu_pkg::frm_t    frm,
    input  fpu_pkg::word_t   a,
    input  fpu_pkg::word_t   b,
    output fpu_pkg::word_t   result,
    output fpu_pkg::fflags_t fflags
);

    localparam fpu_pkg::word_t INT_MAX = 32'h7fff_ffff;
    localparam fpu_pkg::word_t INT_MIN = 32'h8000_0000;

    logic        a_sign;
    logic [7:0]  a_exp;
    logic [22:0] a_frac;
    logic        a_nan;
    logic        a_snan;
    logic        b_nan;
    logic        b_snan;
    logic        both_zero;
    logic        lt_total;
    logic        eq;
    logic        lt;

    logic [23:0] cvt_man;
    logic [63:0] cvt_fixed;
    logic [31:0] cvt_int;
    logic        cvt_rnd;
    logic        cvt_sticky;
    logic        cvt_up;
    logic [32:0] cvt_mag;
    logic        cvt_ovf;

    logic nv;
    logic nx;

    assign a_sign = a[31];
    assign a_exp  = a[30:23];
    assign a_frac = a[22:0];
    assign a_nan  = (a_exp == 8'hff) && (a_frac != '0);
    assign a_snan = a_nan && !a_frac[22];
    assign b_nan  = (b[30:23] == 8'hff) && (b[22:0] != '0);
    assign b_snan = b_nan && !b[22];

    assign both_zero = (a[30:0] == '0) && (b[30:0] == '0);

    // Total order with -0 below +0 for min/max
    always_comb begin
        if (a[31] != b[31]) begin
            lt_total = a[31];
        end else if (a[31]) begin
            lt_total = a[30:0] > b[30:0];
        end else begin
            lt_total = a[30:0] < b[30:0];
        end
    end

    assign eq = (a == b) || both_zero;
    assign lt = lt_total && !both_zero;

    // Fixed point with 32 integer and 32 fraction bits
    assign cvt_man = {a_exp != 8'd0, a_frac};

    always_comb begin
        if (a_exp >= 8'd118) begin
            cvt_fixed = {40'b0, cvt_man} << (a_exp - 8'd118);
        end else begin
            cvt_fixed = '0;
        end
    end

    assign cvt_int    = cvt_fixed[63:32];
    assign cvt_rnd    = cvt_fixed[31];
    assign cvt_sticky = (|cvt_fixed[30:0]) || ((a_exp < 8'd118) && (a[30:0] != '0));

    always_comb begin
        case (frm)
            fpu_pkg::FRM_RTZ: cvt_up = 1'b0;
            fpu_pkg::FRM_RDN: cvt_up = a_sign && (cvt_rnd || cvt_sticky);
            fpu_pkg::FRM_RUP: cvt_up = !a_sign && (cvt_rnd || cvt_sticky);
            fpu_pkg::FRM_RMM: cvt_up = cvt_rnd;
            default:          cvt_up = cvt_rnd && (cvt_sticky || cvt_int[0]);
        endcase
    end

    assign cvt_mag = {1'b0, cvt_int} + 33'(cvt_up);
    // Exponent 159 and up is beyond 2^31 and covers inf and NaN
    assign cvt_ovf = (a_exp >= 8'd159)
                  || (a_sign ? (cvt_mag > 33'h0_8000_0000) : (cvt_mag > 33'h0_7fff_ffff));

    always_comb begin
        result = '0;
        nv     = 1'b0;
        nx     = 1'b0;
        case (op)
            fpu_pkg::FPU_CVT_WS: begin
                if (a_nan) begin
                    result = INT_MAX;
                    nv     = 1'b1;
                end else if (cvt_ovf) begin
                    result = a_sign ? INT_MIN : INT_MAX;
                    nv     = 1'b1;
                end else begin
                    result = a_sign ? (~cvt_mag[31:0] + 32'd1) : cvt_mag[31:0];
                    nx     = cvt_rnd || cvt_sticky;
                end
            end
            fpu_pkg::FPU_MIN, fpu_pkg::FPU_MAX: begin
                nv = a_snan || b_snan;
                if (a_nan && b_nan) begin
                    result = fpu_pkg::CANONICAL_NAN;
                end else if (a_nan) begin
                    result = b;
                end else if (b_nan) begin
                    result = a;
                end else if (op == fpu_pkg::FPU_MIN) begin
                    result = lt_total ? a : b;
                end else begin
                    result = lt_total ? b : a;
                end
            end
            fpu_pkg::FPU_EQ: begin
                nv     = a_snan || b_snan;
                result = 32'(!a_nan && !b_nan && eq);
            end
            fpu_pkg::FPU_LT: begin
                nv     = a_nan || b_nan;
                result = 32'(!a_nan && !b_nan && lt);
            end
            fpu_pkg::FPU_LE: begin
                nv     = a_nan || b_nan;
                result = 32'(!a_nan && !b_nan && (lt || eq));
            end
            fpu_pkg::FPU_SGNJ: begin
                // frm selects plain, negated or xor sign
                case (frm)
                    3'd1:    result = {~b[31], a[30:0]};
                    3'd2:    result = {a[31] ^ b[31], a[30:0]};
                    default: result = {b[31], a[30:0]};
                endcase
            end
            default: result = '0;
        endcase
    end

    // No divide, overflow or underflow source in these ops
    always_comb begin
        fflags                   = '0;
        fflags[fpu_pkg::FLAG_NV] = nv;
        fflags[fpu_pkg::FLAG_DZ] = 1'b0;
        fflags[fpu_pkg::FLAG_OF] = 1'b0;
        fflags[fpu_pkg::FLAG_UF] = 1'b0;
        fflags[fpu_pkg::FLAG_NX] = nx;
    end

endmodule

/* rtl/fpu_pkg.sv */
package fpu_pkg;

    localparam int WORD_BITS   = 32;
    localparam int WID_BITS    = 2;
    localparam int FFLAGS_BITS = 5;
    localparam int FRM_BITS    = 3;

    typedef logic [WORD_BITS-1:0]   word_t;
    typedef logic [WID_BITS-1:0]    wid_t;
    typedef logic [FFLAGS_BITS-1:0] fflags_t;
    typedef logic [FRM_BITS-1:0]    frm_t;

    // Rounding modes in RISC-V encoding
    localparam frm_t FRM_RNE = 3'd0;
    localparam frm_t FRM_RTZ = 3'd1;
    localparam frm_t FRM_RDN = 3'd2;
    localparam frm_t FRM_RUP = 3'd3;
    localparam frm_t FRM_RMM = 3'd4;
    localparam frm_t FRM_DYN = 3'd7;

    // Flag bit positions inside fflags_t
    localparam int FLAG_NV = 4;
    localparam int FLAG_DZ = 3;
    localparam int FLAG_OF = 2;
    localparam int FLAG_UF = 1;
    localparam int FLAG_NX = 0;

    localparam word_t CANONICAL_NAN = 32'h7fc0_0000;

    typedef enum logic [2:0] {
        FPU_CVT_WS = 3'd0,
        FPU_MIN    = 3'd1,
        FPU_MAX    = 3'd2,
        FPU_EQ     = 3'd3,
        FPU_LT     = 3'd4,
        FPU_LE     = 3'd5,
        FPU_SGNJ   = 3'd6
    } fpu_op_t;

    // Header is {wid, tmask, pid, eop}
    function automatic int header_width(int num_lanes, int pid_bits);
        return WID_BITS + num_lanes + pid_bits + 1;
    endfunction

endpackage

/* rtl/fpu_tag_store.sv */
`timescale 1ns/1ps

module fpu_tag_store #(
    parameter int  QUEUE_SIZE = 4,
    parameter int  DATA_WIDTH = 8,
    localparam int TAG_WIDTH  = (QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  acquire,
    input  logic [DATA_WIDTH-1:0] write_data,
    output logic [TAG_WIDTH-1:0]  write_tag,
    input  logic                  release_en,
    input  logic [TAG_WIDTH-1:0]  read_tag,
    output logic [DATA_WIDTH-1:0] read_data,
    output logic                  full
);

    logic [QUEUE_SIZE-1:0] used;
    logic [DATA_WIDTH-1:0] entries [QUEUE_SIZE];

    // Lowest free slot wins
    always_comb begin
        write_tag = '0;
        for (int i = QUEUE_SIZE - 1; i >= 0; i--) begin
            if (!used[i]) begin
                write_tag = TAG_WIDTH'(i);
            end
        end
    end

    assign full      = &used;
    assign read_data = entries[read_tag];

    always_ff @(posedge clk) begin
        if (reset) begin
            used <= '0;
        end else begin
            if (acquire) begin
                used[write_tag] <= 1'b1;
            end
            if (release_en) begin
                used[read_tag] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acquire) begin
            entries[write_tag] <= write_data;
        end
    end

endmodule

/* rtl/fpu_unit.sv */
`timescale 1ns/1ps

module fpu_unit #(
    parameter int  NUM_LANES   = 2,
    parameter int  NUM_THREADS = 4,
    parameter int  QUEUE_SIZE  = 4,
    localparam int PID_BITS    = (NUM_THREADS > NUM_LANES)
                               ? $clog2(NUM_THREADS / NUM_LANES) : 1
) (
    input  logic                            clk,
    input  logic                            reset,

    input  logic                            req_valid,
    output logic                            req_ready,
    input  fpu_pkg::fpu_op_t                req_op,
    input  fpu_pkg::frm_t                   req_frm,
    input  fpu_pkg::wid_t                   req_wid,
    input  logic [NUM_LANES-1:0]            req_tmask,
    input  logic [PID_BITS-1:0]             req_pid,
    input  logic                            req_eop,
    input  fpu_pkg::word_t [NUM_LANES-1:0]  req_a,
    input  fpu_pkg::word_t [NUM_LANES-1:0]  req_b,

    output fpu_pkg::wid_t                   csr_read_wid,
    input  fpu_pkg::frm_t                   csr_read_frm,
    output logic                            csr_write_enable,
    output fpu_pkg::wid_t                   csr_write_wid,
    output fpu_pkg::fflags_t                csr_write_fflags,

    output logic                            rsp_valid,
    input  logic                            rsp_ready,
    output fpu_pkg::wid_t                   rsp_wid,
    output logic [NUM_LANES-1:0]            rsp_tmask,
    output logic [PID_BITS-1:0]             rsp_pid,
    output logic                            rsp_eop,
    output fpu_pkg::word_t [NUM_LANES-1:0]  rsp_data
);

    localparam int TAG_WIDTH = (QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1;
    localparam int HDR_BITS  = fpu_pkg::header_width(NUM_LANES, PID_BITS);

    logic [HDR_BITS-1:0]  req_hdr;
    logic [HDR_BITS-1:0]  rsp_hdr;
    logic [TAG_WIDTH-1:0] req_tag;
    logic [TAG_WIDTH-1:0] rsp_tag;
    logic                 tags_full;

    logic                 core_valid;
    logic                 core_ready;
    fpu_pkg::frm_t        core_frm;
    fpu_pkg::fflags_t     core_fflags;
    logic                 core_has_fflags;

    logic                 req_fire;
    logic                 rsp_fire;

    assign req_hdr = {req_wid, req_tmask, req_pid, req_eop};
    assign {rsp_wid, rsp_tmask, rsp_pid, rsp_eop} = rsp_hdr;

    // Dynamic rounding comes from the warp's CSR except for sign injection
    assign csr_read_wid = req_wid;
    assign core_frm = (req_op != fpu_pkg::FPU_SGNJ && req_frm == fpu_pkg::FRM_DYN)
                    ? csr_read_frm : req_frm;

    assign core_valid = req_valid && !tags_full;
    assign req_ready  = core_ready && !tags_full;
    assign req_fire   = req_valid && req_ready;
    assign rsp_fire   = rsp_valid && rsp_ready;

    fpu_tag_store #(
        .QUEUE_SIZE (QUEUE_SIZE),
        .DATA_WIDTH (HDR_BITS)
    ) i_fpu_tag_store (
        .clk        (clk),
        .reset      (reset),
        .acquire    (req_fire),
        .write_data (req_hdr),
        .write_tag  (req_tag),
        .release_en (rsp_fire),
        .read_tag   (rsp_tag),
        .read_data  (rsp_hdr),
        .full       (tags_full)
    );

    fpu_core #(
        .NUM_LANES (NUM_LANES),
        .TAG_WIDTH (TAG_WIDTH)
    ) i_fpu_core (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (core_valid),
        .in_ready   (core_ready),
        .op         (req_op),
        .frm        (core_frm),
        .mask       (req_tmask),
        .a          (req_a),
        .b          (req_b),
        .in_tag     (req_tag),
        .out_valid  (rsp_valid),
        .out_ready  (rsp_ready),
        .out_tag    (rsp_tag),
        .result     (rsp_data),
        .fflags     (core_fflags),
        .has_fflags (core_has_fflags)
    );

    fpu_fflags_acc i_fpu_fflags_acc (
        .clk              (clk),
        .reset            (reset),
        .fire             (rsp_fire),
        .eop              (rsp_eop),
        .has_fflags       (core_has_fflags),
        .wid              (rsp_wid),
        .fflags           (core_fflags),
        .csr_write_enable (csr_write_enable),
        .csr_write_wid    (csr_write_wid),
        .csr_write_fflags (csr_write_fflags)
    );

endmodule

/* testbench/fpu_stimulus.txt */
# Warp rounding modes w0..w3, then one request per line, all hex:
# phase op frm wid tmask pid eop a0 b0 a1 b1 res0 res1 instr_flags (phase 0 random, 1 single, 2 stall)
0 1 2 3
0 0 7 0 3 0 1 40200000 00000000 C0200000 00000000 00000002 FFFFFFFE 01
0 0 7 3 3 0 1 40200000 00000000 C0200000 00000000 00000003 FFFFFFFE 01
0 0 7 2 3 0 1 40200000 00000000 C0200000 00000000 00000002 FFFFFFFD 01
0 0 3 2 3 0 1 40200000 00000000 C0200000 00000000 00000003 FFFFFFFE 01
0 0 7 1 3 0 1 3FE00000 00000000 3F000000 00000000 00000001 00000000 01
0 0 4 1 3 0 1 3FE00000 00000000 BF000000 00000000 00000002 FFFFFFFF 01
0 0 0 0 3 0 1 40400000 00000000 CF000000 00000000 00000003 80000000 00
0 0 1 0 3 0 1 4F000000 00000000 7FC00000 00000000 7FFFFFFF 7FFFFFFF 10
0 0 1 0 1 0 1 40400000 00000000 7FC00000 00000000 00000003 7FFFFFFF 00
0 1 0 0 3 0 1 3F800000 40000000 80000000 00000000 3F800000 80000000 00
0 2 0 1 3 0 1 3F800000 40000000 80000000 00000000 40000000 00000000 00
0 1 0 2 3 0 1 7FC00000 40400000 7FA00000 7FC00000 40400000 7FC00000 10
0 2 0 3 3 0 1 7FA00000 3F800000 BF800000 C0000000 3F800000 BF800000 10
0 3 0 0 3 0 1 3F800000 3F800000 00000000 80000000 00000001 00000001 00
0 3 0 1 3 0 1 7FC00000 3F800000 7FA00000 3F800000 00000000 00000000 10
0 4 0 2 3 0 1 3F800000 40000000 80000000 00000000 00000001 00000000 00
0 4 0 3 3 0 1 C0000000 BF800000 7FC00000 3F800000 00000001 00000000 10
0 5 0 0 3 0 1 40000000 40000000 80000000 00000000 00000001 00000001 00
0 6 7 1 3 0 1 3F800000 C0000000 BF800000 3F800000 BF800000 3F800000 00
0 6 1 1 3 0 1 3F800000 C0000000 BF800000 3F800000 3F800000 BF800000 00
0 6 2 2 3 0 1 BF800000 C0000000 3F800000 C0000000 3F800000 BF800000 00
0 0 7 3 3 0 0 3FE00000 00000000 40400000 00000000 00000002 00000003 11
0 0 7 3 3 1 1 7FC00000 00000000 40000000 00000000 7FFFFFFF 00000002 11
1 1 0 0 3 0 1 3F800000 40000000 BF800000 C0000000 3F800000 C0000000 00
1 5 0 1 3 0 1 7FC00000 3F800000 3F800000 3F800000 00000000 00000001 10
1 0 7 2 3 0 1 BF000000 00000000 3F000000 00000000 FFFFFFFF 00000000 01
2 2 0 0 3 0 1 3F800000 40000000 C0000000 BF800000 40000000 BF800000 00
2 3 0 1 3 0 1 40000000 40000000 40000000 3F800000 00000001 00000000 00
2 0 1 2 3 0 1 40200000 00000000 C0200000 00000000 00000002 FFFFFFFE 01
2 6 0 3 3 0 1 3F800000 C0000000 BF800000 40000000 BF800000 3F800000 00
2 4 0 0 3 0 1 40000000 3F800000 BF800000 3F800000 00000000 00000001 00
2 0 7 3 3 0 1 3F000000 00000000 BF000000 00000000 00000001 00000000 01

/* testbench/fpu_unit_props.sv */
`timescale 1ns/1ps

module fpu_unit_props #(
    parameter int NUM_LANES = 2,
    parameter int PID_BITS  = 1
) (
    input logic                           clk,
    input logic                           reset,
    input logic                           rsp_valid,
    input logic                           rsp_ready,
    input fpu_pkg::wid_t                  rsp_wid,
    input logic [NUM_LANES-1:0]           rsp_tmask,
    input logic [PID_BITS-1:0]            rsp_pid,
    input logic                           rsp_eop,
    input fpu_pkg::word_t [NUM_LANES-1:0] rsp_data,
    input logic                           has_fflags,
    input logic                           csr_write_enable
);

    logic rsp_fire;

    assign rsp_fire = rsp_valid && rsp_ready;

    // Stalled response keeps its header and data
    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data)
            && $stable({rsp_wid, rsp_tmask, rsp_pid, rsp_eop}))
        else $error("Response changed while rsp_ready was low");

    a_reset_state: assert property (@(posedge clk)
        reset |=> !rsp_valid && !csr_write_enable)
        else $error("Response or CSR write active in reset");

    a_csr_after_eop: assert property (@(posedge clk) disable iff (reset)
        rsp_fire && rsp_eop && has_fflags |=> csr_write_enable)
        else $error("No CSR write after the last packet");

    a_csr_only_after_eop: assert property (@(posedge clk) disable iff (reset)
        csr_write_enable |-> $past(rsp_fire && rsp_eop && has_fflags))
        else $error("CSR write without a last packet before it");

endmodule

/* testbench/fpu_unit_tb.sv */
`timescale 1ns/1ps

module fpu_unit_tb;

    localparam int NUM_LANES          = 2;
    localparam int NUM_THREADS        = 4;
    localparam int QUEUE_SIZE         = 4;
    localparam int PID_BITS           = 1;
    localparam int CLK_PERIOD         = 40;
    localparam int RESET_CYCLES       = 16;
    localparam int DRIVE_DELAY        = 2;
    localparam int STALL_CYCLES       = 12;
    localparam int CYCLES_PER_REQUEST = 40;
    localparam int MAX_REQUESTS       = 64;
    localparam string STIMULUS_FILE   = "testbench/fpu_stimulus.txt";

    logic                           clk;
    logic                           reset;
    logic                           req_valid;
    logic                           req_ready;
    fpu_pkg::fpu_op_t               req_op;
    fpu_pkg::frm_t                  req_frm;
    fpu_pkg::wid_t                  req_wid;
    logic [NUM_LANES-1:0]           req_tmask;
    logic [PID_BITS-1:0]            req_pid;
    logic                           req_eop;
    fpu_pkg::word_t [NUM_LANES-1:0] req_a;
    fpu_pkg::word_t [NUM_LANES-1:0] req_b;
    fpu_pkg::wid_t                  csr_read_wid;
    fpu_pkg::frm_t                  csr_read_frm;
    logic                           csr_write_enable;
    fpu_pkg::wid_t                  csr_write_wid;
    fpu_pkg::fflags_t               csr_write_fflags;
    logic                           rsp_valid;
    logic                           rsp_ready;
    fpu_pkg::wid_t                  rsp_wid;
    logic [NUM_LANES-1:0]           rsp_tmask;
    logic [PID_BITS-1:0]            rsp_pid;
    logic                           rsp_eop;
    fpu_pkg::word_t [NUM_LANES-1:0] rsp_data;

    // Stimulus table with one entry per request line
    logic [1:0]           stim_phase [MAX_REQUESTS];
    logic [2:0]           stim_op    [MAX_REQUESTS];
    fpu_pkg::frm_t        stim_frm   [MAX_REQUESTS];
    fpu_pkg::wid_t        stim_wid   [MAX_REQUESTS];
    logic [NUM_LANES-1:0] stim_tmask [MAX_REQUESTS];
    logic [PID_BITS-1:0]  stim_pid   [MAX_REQUESTS];
    logic                 stim_eop   [MAX_REQUESTS];
    fpu_pkg::word_t       stim_a     [MAX_REQUESTS][NUM_LANES];
    fpu_pkg::word_t       stim_b     [MAX_REQUESTS][NUM_LANES];
    fpu_pkg::word_t       stim_res   [MAX_REQUESTS][NUM_LANES];
    fpu_pkg::fflags_t     stim_flags [MAX_REQUESTS];
    fpu_pkg::frm_t        warp_frm   [4];

    int               num_requests;
    int               cur_idx;
    int               accepted;
    int               responses;
    int               checks;
    int               errors;
    int               exp_q [$];
    bit               load_done;
    int               rsp_mode;
    integer           seed;
    bit               write_pending;
    fpu_pkg::wid_t    write_wid;
    fpu_pkg::fflags_t write_flags;

    // CSR file answers in the same cycle
    assign csr_read_frm = warp_frm[csr_read_wid];

    fpu_unit #(
        .NUM_LANES   (NUM_LANES),
        .NUM_THREADS (NUM_THREADS),
        .QUEUE_SIZE  (QUEUE_SIZE)
    ) i_fpu_unit (.*);

    bind fpu_unit fpu_unit_props #(
        .NUM_LANES (NUM_LANES),
        .PID_BITS  (PID_BITS)
    ) i_fpu_unit_props (
        .clk              (clk),
        .reset            (reset),
        .rsp_valid        (rsp_valid),
        .rsp_ready        (rsp_ready),
        .rsp_wid          (rsp_wid),
        .rsp_tmask        (rsp_tmask),
        .rsp_pid          (rsp_pid),
        .rsp_eop          (rsp_eop),
        .rsp_data         (rsp_data),
        .has_fflags       (core_has_fflags),
        .csr_write_enable (csr_write_enable)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          count;
        string       line;
        bit          have_modes;
        logic [31:0] m [4];
        logic [31:0] fld [14];
        fd = $fopen(STIMULUS_FILE, "r");
        have_modes = 1'b0;
        if (fd == 0) begin
            errors++;
            $display("Cannot open the stimulus file %s", STIMULUS_FILE);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if (!have_modes) begin
                count = $sscanf(line, "%h %h %h %h", m[0], m[1], m[2], m[3]);
                for (int w = 0; w < 4; w++) begin
                    warp_frm[w] = m[w][2:0];
                end
                have_modes = (count == 4);
            end else begin
                count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                                fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13]);
                if (count != 14 || num_requests >= MAX_REQUESTS) begin
                    errors++;
                    $display("Stimulus line could not be used: %s", line);
                end else begin
                    stim_phase[num_requests]  = fld[0][1:0];
                    stim_op[num_requests]     = fld[1][2:0];
                    stim_frm[num_requests]    = fld[2][2:0];
                    stim_wid[num_requests]    = fld[3][1:0];
                    stim_tmask[num_requests]  = fld[4][NUM_LANES-1:0];
                    stim_pid[num_requests]    = fld[5][PID_BITS-1:0];
                    stim_eop[num_requests]    = fld[6][0];
                    stim_a[num_requests][0]   = fld[7];
                    stim_b[num_requests][0]   = fld[8];
                    stim_a[num_requests][1]   = fld[9];
                    stim_b[num_requests][1]   = fld[10];
                    stim_res[num_requests][0] = fld[11];
                    stim_res[num_requests][1] = fld[12];
                    stim_flags[num_requests]  = fld[13][4:0];
                    num_requests++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Starts and ends a drive delay after a rising edge
    task automatic send_request(input int i);
        cur_idx   = i;
        req_op    = fpu_pkg::fpu_op_t'(stim_op[i]);
        req_frm   = stim_frm[i];
        req_wid   = stim_wid[i];
        req_tmask = stim_tmask[i];
        req_pid   = stim_pid[i];
        req_eop   = stim_eop[i];
        for (int l = 0; l < NUM_LANES; l++) begin
            req_a[l] = stim_a[i][l];
            req_b[l] = stim_b[i][l];
        end
        req_valid = 1'b1;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic drain();
        rsp_mode = 1;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic hold_back_pressure();
        int base;
        base = accepted;
        repeat (STALL_CYCLES) @(negedge clk);
        if (accepted - base > QUEUE_SIZE) begin
            errors++;
            $display("More than %0d requests accepted while responses were held", QUEUE_SIZE);
        end
        check_value("req_ready", req_ready, 1'b0);
        rsp_mode = 1;
    endtask

    task automatic run_tests();
        for (int i = 0; i < num_requests; i++) begin
            if (i == 0 || stim_phase[i] != stim_phase[i-1]) begin
                req_valid = 1'b0;
                drain();
                rsp_mode = int'(stim_phase[i]);
                @(posedge clk);
                #DRIVE_DELAY;
                if (stim_phase[i] == 2'd2) begin
                    fork
                        hold_back_pressure();
                    join_none
                end
            end
            send_request(i);
            if (stim_phase[i] == 2'd1) begin
                // Response due two cycles after fire
                req_valid = 1'b0;
                @(negedge clk);
                check_value("rsp_valid", rsp_valid, 1'b0);
                @(negedge clk);
                check_value("rsp_valid", rsp_valid, 1'b1);
                drain();
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        req_valid = 1'b0;
        drain();
        repeat (3) @(negedge clk);
    endtask

    initial begin
        rsp_ready = 1'b0;
        seed      = 95313;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            case (rsp_mode)
                0:       rsp_ready = ($random(seed) & 3) != 0;
                1:       rsp_ready = 1'b1;
                default: rsp_ready = 1'b0;
            endcase
        end
    end

    // Monitor on the falling edge
    always @(negedge clk) begin
        int idx;
        if (!reset) begin
            if (write_pending) begin
                check_value("csr_write_enable", csr_write_enable, 1'b1);
                check_value("csr_write_wid", csr_write_wid, write_wid);
                check_value("csr_write_fflags", csr_write_fflags, write_flags);
            end else begin
                check_value("csr_write_enable", csr_write_enable, 1'b0);
            end
            write_pending = 1'b0;
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("A response arrived with no request outstanding");
                end else begin
                    idx = exp_q.pop_front();
                    responses++;
                    check_value("rsp_wid", rsp_wid, stim_wid[idx]);
                    check_value("rsp_tmask", rsp_tmask, stim_tmask[idx]);
                    check_value("rsp_pid", rsp_pid, stim_pid[idx]);
                    check_value("rsp_eop", rsp_eop, stim_eop[idx]);
                    for (int l = 0; l < NUM_LANES; l++) begin
                        if (stim_tmask[idx][l]) begin
                            check_value($sformatf("rsp_data[%0d]", l), rsp_data[l],
                                        stim_res[idx][l]);
                        end
                    end
                    if (stim_eop[idx] && stim_op[idx] != fpu_pkg::FPU_SGNJ) begin
                        write_pending = 1'b1;
                        write_wid     = stim_wid[idx];
                        write_flags   = stim_flags[idx];
                    end
                end
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(cur_idx);
                accepted++;
            end
        end
    end

    initial begin
        wait (load_done);
        #((num_requests * CYCLES_PER_REQUEST + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout after %0d of %0d responses, the DUT stopped making progress",
                 responses, num_requests);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req_op    = fpu_pkg::FPU_CVT_WS;
        req_frm   = fpu_pkg::FRM_RNE;
        req_wid   = '0;
        req_tmask = '0;
        req_pid   = '0;
        req_eop   = 1'b0;
        req_a     = '0;
        req_b     = '0;
        rsp_mode  = 1;
        for (int w = 0; w < 4; w++) begin
            warp_frm[w] = fpu_pkg::FRM_RNE;
        end
        load_stimulus();
        if (num_requests == 0) begin
            errors++;
            $display("The stimulus file holds no usable request");
        end
        load_done = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        if (num_requests > 0) begin
            run_tests();
        end
        check_value("response count", responses, num_requests);
        $display("Checks: %0d, errors: %0d, responses: %0d", checks, errors, responses);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
